// ==== sim.f ====
+incdir+include
hw/mmio_pkg.sv
hw/mmio_reg_if.sv
hw/mmio_access_fsm.sv
hw/mmio_global_regs.sv
hw/soft_reset_timer.sv
hw/mmio_top.sv
tb/mmio_assert.sv
tb/mmio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MMIO slave testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mmio_tb -f sim.f -o mmio_sim
./obj_dir/mmio_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "^Verification passed$" sim.log
then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb/mmio_tb.sv ====
/*
 * MMIO slave testbench
 * Table-driven host accesses against mmio_top, with an action-side
 * responder model, reply latency checks and soft-reset checks
 */
`default_nettype none
`include "mmio_defs.svh"

module mmio_tb;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_ROWS   = 25;
   localparam int MAX_WAIT   = 30;                   // Cycles per access before giving up
   localparam int WATCHDOG_T = (NUM_ROWS * 40 + 8) * CLK_PERIOD;
   localparam int DBG_W      = 3 * `MMIO_DATA_W + `FIR_BRIDGE_W;
   localparam logic [`LCL_DATA_W-1:0] ACT_RDATA = 32'hA5C3_1E70;   // Model read data

   // Debug bus {fir, axi_cmd, axi_rsp, buf_cnt}
   localparam logic [DBG_W-1:0] DBG_IDLE = {4'h0, 64'h0000_0000_0000_0123,
                                            64'h0000_0000_0000_0123, 64'h0};
   localparam logic [DBG_W-1:0] DBG_BUSY = {4'h5, 64'h1111_2222_3333_4444,
                                            64'h5555_6666_7777_8888, 64'h9};

   localparam int NONE = 0;                          // Extra check per row
   localparam int SRST = 1;
   localparam int CLR  = 2;
   localparam int NOSR = 3;                          // Soft reset must stay low

   logic                     clk;
   logic                     rst_n;
   logic [DBG_W-1:0]         debug_bus;
   logic                     debug_info_clear;
   logic                     soft_reset_brdg_odma;
   logic                     soft_reset_action;
   logic                     mmio_wr;
   logic                     mmio_rd;
   logic                     mmio_dw;
   logic [`MMIO_ADDR_W-1:0]  mmio_addr;
   logic [`MMIO_DATA_W-1:0]  mmio_din;
   logic [`MMIO_DATA_W-1:0]  mmio_dout;
   logic                     mmio_done;
   logic                     mmio_failed;
   logic                     lcl_mmio_wr;
   logic                     lcl_mmio_rd;
   logic [`MMIO_ADDR_W-1:0]  lcl_mmio_addr;
   logic [`LCL_DATA_W-1:0]   lcl_mmio_din;
   logic                     lcl_mmio_ack;
   logic                     lcl_mmio_rsp;
   logic [`LCL_DATA_W-1:0]   lcl_mmio_dout;
   logic                     lcl_mmio_dv;

   // Stimulus and expectation table
   logic                     t_wr     [NUM_ROWS];
   logic [`MMIO_ADDR_W-1:0]  t_addr   [NUM_ROWS];
   logic                     t_dw     [NUM_ROWS];
   logic [`MMIO_DATA_W-1:0]  t_din    [NUM_ROWS];
   logic [DBG_W-1:0]         t_dbg    [NUM_ROWS];
   logic                     t_rsp    [NUM_ROWS];   // Action answer good/bad
   logic [`MMIO_DATA_W-1:0]  t_dout   [NUM_ROWS];
   logic                     t_ok     [NUM_ROWS];   // 1 done, 0 failed
   int                       t_kind   [NUM_ROWS];
   int                       n_rows = 0;

   int                       n_checks = 0;
   int                       n_err = 0;
   integer                   seed;
   logic                     row_rsp;                // Responder answer for this row
   int                       strobe_cnt = 0;
   int                       act_delay = 0;
   logic                     seen_wr;
   logic [`MMIO_ADDR_W-1:0]  seen_addr;
   logic [`LCL_DATA_W-1:0]   seen_din;

   mmio_top dut_i
   (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .debug_bus_data_bridge (debug_bus),
      .debug_info_clear      (debug_info_clear),
      .soft_reset_brdg_odma  (soft_reset_brdg_odma),
      .soft_reset_action     (soft_reset_action),
      .mmio_wr               (mmio_wr),
      .mmio_rd               (mmio_rd),
      .mmio_dw               (mmio_dw),
      .mmio_addr             (mmio_addr),
      .mmio_din              (mmio_din),
      .mmio_dout             (mmio_dout),
      .mmio_done             (mmio_done),
      .mmio_failed           (mmio_failed),
      .lcl_mmio_wr           (lcl_mmio_wr),
      .lcl_mmio_rd           (lcl_mmio_rd),
      .lcl_mmio_addr         (lcl_mmio_addr),
      .lcl_mmio_din          (lcl_mmio_din),
      .lcl_mmio_ack          (lcl_mmio_ack),
      .lcl_mmio_rsp          (lcl_mmio_rsp),
      .lcl_mmio_dout         (lcl_mmio_dout),
      .lcl_mmio_dv           (lcl_mmio_dv)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   function automatic logic [`MMIO_ADDR_W-1:0] glb_addr(input logic [`MMIO_BASE_W-1:0] base,
                                                        input logic [`MMIO_OFFSET_W-1:0] ofs);
      glb_addr = {{(`MMIO_ADDR_W-`MMIO_BASE_W-`MMIO_OFFSET_W){1'b0}}, base, ofs};
   endfunction

   task automatic add_row(input logic wr, input logic [`MMIO_ADDR_W-1:0] addr,
                          input logic dw, input logic [`MMIO_DATA_W-1:0] din,
                          input logic [DBG_W-1:0] dbg, input logic rsp,
                          input logic [`MMIO_DATA_W-1:0] dout, input logic ok,
                          input int kind);
      t_wr[n_rows]   = wr;
      t_addr[n_rows] = addr;
      t_dw[n_rows]   = dw;
      t_din[n_rows]  = din;
      t_dbg[n_rows]  = dbg;
      t_rsp[n_rows]  = rsp;
      t_dout[n_rows] = dout;
      t_ok[n_rows]   = ok;
      t_kind[n_rows] = kind;
      n_rows++;
   endtask

   task automatic compare_word(input logic [`MMIO_DATA_W-1:0] got,
                               input logic [`MMIO_DATA_W-1:0] want, input string what);
      n_checks++;
      assert (got === want)
      else
      begin
         n_err++;
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   // Starts on the done negedge and expects cycles 2 to 17 high when a pulse is due
   task automatic watch_soft_reset(input int row, input logic pulse);
      int   k;
      logic want;
      for (k = 1; k < 20; k++)
      begin
         @(negedge clk);
         want = pulse && (k >= 2 && k <= 17);
         compare_word(soft_reset_brdg_odma, want, $sformatf("row %0d soft_reset_brdg_odma", row));
         compare_word(soft_reset_action, want, $sformatf("row %0d soft_reset_action", row));
      end
   endtask

   // ========================================================================
   // Action responder model
   // ========================================================================
   initial
   begin
      seed          = 32'h9f23;
      lcl_mmio_ack  = 1'b0;
      lcl_mmio_dv   = 1'b0;
      lcl_mmio_rsp  = 1'b0;
      lcl_mmio_dout = '0;
      forever
      begin
         @(negedge clk);
         if (lcl_mmio_wr || lcl_mmio_rd)
         begin
            strobe_cnt++;
            seen_wr   = lcl_mmio_wr;
            seen_addr = lcl_mmio_addr;               // Valid with the strobe
            seen_din  = lcl_mmio_din;
            act_delay = int'({$random(seed)} % 6);   // 0 to 5 cycles
            repeat (act_delay) @(posedge clk);
            @(posedge clk);
            #1;
            lcl_mmio_ack  = seen_wr;
            lcl_mmio_dv   = ~seen_wr;
            lcl_mmio_rsp  = row_rsp;
            lcl_mmio_dout = ACT_RDATA;
            @(posedge clk);
            #1;
            lcl_mmio_ack  = 1'b0;
            lcl_mmio_dv   = 1'b0;
            lcl_mmio_rsp  = 1'b0;
            lcl_mmio_dout = '0;
         end
      end
   end

   // ========================================================================
   // Main sequence
   // ========================================================================
   initial
   begin
      int   i;
      int   lat;
      int   want_lat;
      int   strobes_before;
      logic got_done;
      logic got_failed;
      logic got_clr;
      logic width_bad;
      rst_n     = 1'b0;
      mmio_wr   = 1'b0;
      mmio_rd   = 1'b0;
      mmio_dw   = 1'b0;
      mmio_addr = '0;
      mmio_din  = '0;
      debug_bus = DBG_IDLE;
      row_rsp   = 1'b1;

      // Identity and snapshots
      add_row(0, glb_addr(`BASE_INFRA, `OFS_IMP_VERSION), 1, 0, DBG_IDLE, 1,
              `MMIO_IMP_VERSION, 1, NONE);
      add_row(0, glb_addr(`BASE_INFRA, `OFS_BUILD_DATE), 1, 0, DBG_IDLE, 1,
              `MMIO_BUILD_DATE, 1, NONE);
      add_row(0, glb_addr(`BASE_INFRA, `OFS_CAPABILITY), 1, 0, DBG_IDLE, 1,
              {`MMIO_OTHER_CAP, `MMIO_CARD_TYPE}, 1, NONE);
      add_row(0, glb_addr(`BASE_INFRA, `OFS_STATUS), 1, 0, DBG_IDLE, 1, 64'h1, 1, NONE);
      add_row(0, glb_addr(`BASE_DEBUG, `OFS_CNT_AXI_CMD), 1, 0, DBG_BUSY, 1,
              64'h1111_2222_3333_4444, 1, NONE);
      add_row(0, glb_addr(`BASE_DEBUG, `OFS_CNT_AXI_RSP), 1, 0, DBG_BUSY, 1,
              64'h5555_6666_7777_8888, 1, NONE);
      add_row(0, glb_addr(`BASE_DEBUG, `OFS_BUF_CNT), 1, 0, DBG_BUSY, 1, 64'h9, 1, NONE);
      add_row(0, glb_addr(`BASE_FIR, `OFS_FIR_BRIDGE), 1, 0, DBG_BUSY, 1, 64'h5, 1, NONE);
      add_row(0, glb_addr(`BASE_INFRA, `OFS_STATUS), 1, 0, DBG_BUSY, 1, 64'hC, 1, NONE);
      // Errors
      add_row(0, glb_addr(`BASE_INFRA, 8'h20), 1, 0, DBG_BUSY, 1, 0, 0, NONE);
      add_row(0, glb_addr(`BASE_INFRA, `OFS_COMMAND), 1, 0, DBG_BUSY, 1, 0, 0, NONE);
      add_row(1, glb_addr(`BASE_INFRA, `OFS_STATUS), 1, 1, DBG_BUSY, 1, 0, 0, NONE);
      add_row(1, glb_addr(`BASE_INFRA, `OFS_IMP_VERSION), 1, 1, DBG_BUSY, 1, 0, 0, NONE);
      add_row(0, glb_addr(14'h0100, 8'h00), 1, 0, DBG_BUSY, 1, 0, 0, NONE);
      add_row(0, 32'h8000_0010, 1, 0, DBG_BUSY, 1, 0, 0, NONE);      // 8 bytes to action
      add_row(0, glb_addr(`BASE_INFRA, `OFS_IMP_VERSION), 0, 0, DBG_BUSY, 1, 0, 0, NONE);
      // Action forwarding
      add_row(1, 32'h8000_0104, 0, 64'hDEAD_BEEF_0BAD_F00D, DBG_BUSY, 1, 0, 1, NONE);
      add_row(1, 32'h8000_0200, 0, 64'hDEAD_BEEF_0BAD_F00D, DBG_BUSY, 1, 0, 1, NONE);
      add_row(0, 32'h8000_0304, 0, 0, DBG_BUSY, 1, {ACT_RDATA, 32'h0}, 1, NONE);
      add_row(0, 32'h8000_0308, 0, 0, DBG_BUSY, 1, {32'h0, ACT_RDATA}, 1, NONE);
      add_row(0, 32'h8000_0400, 0, 0, DBG_BUSY, 0, 0, 0, NONE);
      add_row(1, 32'h8000_0404, 0, 64'h1234, DBG_BUSY, 0, 0, 0, NONE);
      // Command and debug clear
      add_row(1, glb_addr(`BASE_INFRA, `OFS_COMMAND), 1, 64'h1, DBG_IDLE, 1, 0, 1, SRST);
      add_row(1, glb_addr(`BASE_DEBUG, `OFS_DBG_CLEAR), 1, 64'h1, DBG_IDLE, 1, 0, 1, CLR);
      add_row(1, glb_addr(`BASE_INFRA, `OFS_COMMAND), 1, 64'h0, DBG_IDLE, 1, 0, 1, NOSR);

      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;

      for (i = 0; i < n_rows; i++)
      begin
         @(posedge clk);
         #1;
         debug_bus = t_dbg[i];                       // Settles before the snapshot
         row_rsp   = t_rsp[i];
         repeat (2) @(posedge clk);
         #1;
         strobes_before = strobe_cnt;
         mmio_addr = t_addr[i];
         mmio_dw   = t_dw[i];
         mmio_din  = t_din[i];
         mmio_wr   = t_wr[i];
         mmio_rd   = ~t_wr[i];
         @(posedge clk);                             // Request sampled here
         #1;
         mmio_wr = 1'b0;
         mmio_rd = 1'b0;

         lat = 0;
         @(negedge clk);
         while (!(mmio_done || mmio_failed) && lat < MAX_WAIT)
         begin
            @(negedge clk);
            lat++;
         end
         got_done   = mmio_done;
         got_failed = mmio_failed;
         got_clr    = debug_info_clear;
         assert (lat < MAX_WAIT)
         else
         begin
            n_err++;
            $display("Row %0d got neither done nor failed within %0d cycles", i, MAX_WAIT);
         end

         // Global area takes 8-byte accesses and the action area 4-byte ones
         width_bad = (t_dw[i] == t_addr[i][31]);
         if (width_bad)
            want_lat = 0;                            // Rejected at once
         else if (!t_addr[i][31])
            want_lat = 2;
         else
            want_lat = 2 + act_delay;                // Plus the responder delay

         compare_word(got_done, t_ok[i], $sformatf("row %0d done", i));
         compare_word(got_failed, !t_ok[i], $sformatf("row %0d failed", i));
         compare_word(lat, want_lat, $sformatf("row %0d reply latency", i));
         compare_word(got_clr, t_kind[i] == CLR, $sformatf("row %0d debug_info_clear", i));
         compare_word(soft_reset_action, 0, $sformatf("row %0d soft reset at done", i));
         if (!t_wr[i] && t_ok[i])
            compare_word(mmio_dout, t_dout[i], $sformatf("row %0d dout", i));

         if (t_addr[i][31] && !width_bad)
         begin
            compare_word(strobe_cnt, strobes_before + 1, $sformatf("row %0d strobes", i));
            compare_word(seen_wr, t_wr[i], $sformatf("row %0d local direction", i));
            compare_word(seen_addr, t_addr[i] & 32'h7FFF_FFFF,
                         $sformatf("row %0d lcl_mmio_addr", i));
            if (t_wr[i])
               compare_word(seen_din, t_addr[i][2] ? t_din[i][63:32] : t_din[i][31:0],
                            $sformatf("row %0d lcl_mmio_din", i));
         end
         else
            compare_word(strobe_cnt, strobes_before, $sformatf("row %0d no local strobe", i));

         if (t_kind[i] == SRST || t_kind[i] == NOSR)
            watch_soft_reset(i, t_kind[i] == SRST);
         if (t_kind[i] == CLR)
         begin
            @(negedge clk);
            compare_word(debug_info_clear, 0, $sformatf("row %0d clear pulse end", i));
         end
      end

      repeat (4) @(posedge clk);
      $display("Checks: %0d, errors: %0d", n_checks, n_err);
      if (n_err == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // Watchdog allows 40 cycles per row plus reset
   initial
   begin
      #(WATCHDOG_T);
      $display("Timeout after %0d time units, the test sequence did not finish", WATCHDOG_T);
      $display("Checks: %0d, errors: %0d", n_checks, n_err);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/mmio_assert.sv ====
/*
 * MMIO handshake assertions
 * Bound into mmio_top, watch the host reply pulses and the local strobes
 */
`default_nettype none

module mmio_assert
(
   input logic clk,
   input logic rst_n,
   input logic mmio_done,
   input logic mmio_failed,
   input logic lcl_mmio_wr,
   input logic lcl_mmio_rd
);

   logic lcl_busy;                         // Local access not yet answered

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lcl_busy <= 1'b0;
      else if (lcl_mmio_wr || lcl_mmio_rd)
         lcl_busy <= 1'b1;
      else if (mmio_done || mmio_failed)
         lcl_busy <= 1'b0;
   end

   // Only one reply per access
   done_xor_failed: assert property (@(posedge clk) disable iff (!rst_n)
      !(mmio_done && mmio_failed))
      else $error("done and failed high in the same cycle");

   done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      mmio_done |=> !mmio_done)
      else $error("done held longer than one cycle");

   failed_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      mmio_failed |=> !mmio_failed)
      else $error("failed held longer than one cycle");

   single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      (lcl_mmio_wr || lcl_mmio_rd) |-> !lcl_busy)
      else $error("second local strobe before the reply");

endmodule

bind mmio_top mmio_assert assert_i
(
   .clk         (clk),
   .rst_n       (rst_n),
   .mmio_done   (mmio_done),
   .mmio_failed (mmio_failed),
   .lcl_mmio_wr (lcl_mmio_wr),
   .lcl_mmio_rd (lcl_mmio_rd)
);

`default_nettype wire

// ==== hw/mmio_top.sv ====
/*
 * MMIO slave top level
 * Host MMIO port, action local bus, debug input and soft resets
 */
`default_nettype none
`include "mmio_defs.svh"

module mmio_top
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   // Bridge debug
   input  logic [3*`MMIO_DATA_W+`FIR_BRIDGE_W-1:0]  debug_bus_data_bridge,
   output logic                                     debug_info_clear,
   // Soft resets
   output logic                                     soft_reset_brdg_odma,
   output logic                                     soft_reset_action,
   // Host
   input  logic                                     mmio_wr,
   input  logic                                     mmio_rd,
   input  logic                                     mmio_dw,
   input  logic [`MMIO_ADDR_W-1:0]                  mmio_addr,
   input  logic [`MMIO_DATA_W-1:0]                  mmio_din,
   output logic [`MMIO_DATA_W-1:0]                  mmio_dout,
   output logic                                     mmio_done,
   output logic                                     mmio_failed,
   // Action local bus
   output logic                                     lcl_mmio_wr,
   output logic                                     lcl_mmio_rd,
   output logic [`MMIO_ADDR_W-1:0]                  lcl_mmio_addr,
   output logic [`LCL_DATA_W-1:0]                   lcl_mmio_din,
   input  logic                                     lcl_mmio_ack,
   input  logic                                     lcl_mmio_rsp,
   input  logic [`LCL_DATA_W-1:0]                   lcl_mmio_dout,
   input  logic                                     lcl_mmio_dv
);

   logic start_reset;                      // Command write, regs to timer

   mmio_reg_if reg_bus ();

   mmio_access_fsm fsm_i
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .mmio_wr       (mmio_wr),
      .mmio_rd       (mmio_rd),
      .mmio_dw       (mmio_dw),
      .mmio_addr     (mmio_addr),
      .mmio_din      (mmio_din),
      .mmio_dout     (mmio_dout),
      .mmio_done     (mmio_done),
      .mmio_failed   (mmio_failed),
      .lcl_mmio_wr   (lcl_mmio_wr),
      .lcl_mmio_rd   (lcl_mmio_rd),
      .lcl_mmio_addr (lcl_mmio_addr),
      .lcl_mmio_din  (lcl_mmio_din),
      .lcl_mmio_ack  (lcl_mmio_ack),
      .lcl_mmio_rsp  (lcl_mmio_rsp),
      .lcl_mmio_dout (lcl_mmio_dout),
      .lcl_mmio_dv   (lcl_mmio_dv),
      .reg_bus       (reg_bus.seq)
   );

   mmio_global_regs regs_i
   (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .debug_bus_data_bridge (debug_bus_data_bridge),
      .debug_info_clear      (debug_info_clear),
      .start_reset           (start_reset),
      .reg_bus               (reg_bus.regs)
   );

   soft_reset_timer timer_i
   (
      .clk                  (clk),
      .rst_n                (rst_n),
      .start_reset          (start_reset),
      .soft_reset_brdg_odma (soft_reset_brdg_odma),
      .soft_reset_action    (soft_reset_action)
   );

endmodule

`default_nettype wire

// ==== hw/soft_reset_timer.sv ====
/*
 * Soft-reset pulse timer
 * Holds the bridge and action soft resets high for a fixed length
 */
`default_nettype none
`include "mmio_defs.svh"

module soft_reset_timer
(
   input  logic clk,
   input  logic rst_n,
   input  logic start_reset,               // One-cycle command pulse
   output logic soft_reset_brdg_odma,
   output logic soft_reset_action
);

   localparam int CNT_W = $clog2(`SOFT_RESET_CYCLES);

   logic [CNT_W-1:0] cnt;                  // Cycles left after this one
   logic             active;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt    <= '0;
         active <= 1'b0;
      end
      else if (start_reset)
      begin
         cnt    <= CNT_W'(`SOFT_RESET_CYCLES - 1);   // Retrigger restarts the pulse
         active <= 1'b1;
      end
      else if (active)
      begin
         if (cnt == '0)
            active <= 1'b0;
         else
            cnt <= cnt - 1'b1;
      end
   end

   assign soft_reset_brdg_odma = active;   // Both from one timer
   assign soft_reset_action    = active;

endmodule

`default_nettype wire

// ==== hw/mmio_global_regs.sv ====
/*
 * Global MMIO register file
 * Snapshots the data-bridge debug bus, derives status, serves
 * 8-byte reads and decodes the command and debug-clear writes
 */
`default_nettype none
`include "mmio_defs.svh"

module mmio_global_regs
(
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic [3*`MMIO_DATA_W+`FIR_BRIDGE_W-1:0]       debug_bus_data_bridge,
   output logic                                          debug_info_clear,
   output logic                                          start_reset,   // To timer
   mmio_reg_if.regs                                      reg_bus
);

   localparam int FIR_LSB = 3 * `MMIO_DATA_W;

   logic [`MMIO_DATA_W-1:0]  axi_cmd_q;               // Bridge counter snapshots
   logic [`MMIO_DATA_W-1:0]  axi_rsp_q;
   logic [`MMIO_DATA_W-1:0]  buf_cnt_q;
   logic [`FIR_BRIDGE_W-1:0] fir_q;
   logic                     bridge_idle;             // Status bit 0
   logic                     axi_busy;                // Status bit 2
   logic                     fatal_error;             // Status bit 3
   logic [`MMIO_DATA_W-1:0]  status_word;
   logic [`MMIO_DATA_W-1:0]  rd_val;
   logic                     rd_hit;
   logic                     wr_cmd_hit;
   logic                     wr_clr_hit;
   logic                     cmd_q;
   logic                     cmd_qq;
   logic                     clr_q;

   // ========================================================================
   // Debug snapshots and status
   // ========================================================================
   always_ff @(posedge clk)
   begin
      axi_cmd_q   <= debug_bus_data_bridge[3*`MMIO_DATA_W-1 -: `MMIO_DATA_W];
      axi_rsp_q   <= debug_bus_data_bridge[2*`MMIO_DATA_W-1 -: `MMIO_DATA_W];
      buf_cnt_q   <= debug_bus_data_bridge[`MMIO_DATA_W-1:0];
      fir_q       <= debug_bus_data_bridge[FIR_LSB +: `FIR_BRIDGE_W];
      bridge_idle <= (debug_bus_data_bridge[`MMIO_DATA_W-1:0] == '0);  // Buffers empty
      axi_busy    <= (debug_bus_data_bridge[3*`MMIO_DATA_W-1 -: `MMIO_DATA_W] !=
                      debug_bus_data_bridge[2*`MMIO_DATA_W-1 -: `MMIO_DATA_W]);
      fatal_error <= |debug_bus_data_bridge[FIR_LSB +: `FIR_BRIDGE_W];
   end

   // Bit 1 was the protocol busy flag, reads zero
   assign status_word = {{(`MMIO_DATA_W-4){1'b0}}, fatal_error, axi_busy, 1'b0, bridge_idle};

   // ========================================================================
   // Address decode
   // ========================================================================
   always_comb
   begin
      rd_hit = 1'b1;
      rd_val = '0;
      case (reg_bus.addr.glb.base)
         `BASE_INFRA:
            case (reg_bus.addr.glb.offset)
               `OFS_IMP_VERSION: rd_val = `MMIO_IMP_VERSION;
               `OFS_BUILD_DATE:  rd_val = `MMIO_BUILD_DATE;
               `OFS_STATUS:      rd_val = status_word;
               `OFS_CAPABILITY:  rd_val = {`MMIO_OTHER_CAP, `MMIO_CARD_TYPE};
               default:          rd_hit = 1'b0;      // Command is write-only
            endcase
         `BASE_DEBUG:
            case (reg_bus.addr.glb.offset)
               `OFS_CNT_AXI_CMD: rd_val = axi_cmd_q;
               `OFS_CNT_AXI_RSP: rd_val = axi_rsp_q;
               `OFS_BUF_CNT:     rd_val = buf_cnt_q;
               default:          rd_hit = 1'b0;
            endcase
         `BASE_FIR:
            if (reg_bus.addr.glb.offset == `OFS_FIR_BRIDGE)
               rd_val = {{(`MMIO_DATA_W-`FIR_BRIDGE_W){1'b0}}, fir_q};
            else
               rd_hit = 1'b0;
         default:
            rd_hit = 1'b0;
      endcase
   end

   // Only two writable registers
   assign wr_cmd_hit = (reg_bus.addr.glb.base == `BASE_INFRA) &&
                       (reg_bus.addr.glb.offset == `OFS_COMMAND);
   assign wr_clr_hit = (reg_bus.addr.glb.base == `BASE_DEBUG) &&
                       (reg_bus.addr.glb.offset == `OFS_DBG_CLEAR);

   always_ff @(posedge clk)
   begin
      if (reg_bus.rd)
         reg_bus.rdata <= rd_val;
   end

   // ========================================================================
   // Ack and command pulses
   // ========================================================================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         reg_bus.ack      <= 1'b0;
         reg_bus.err      <= 1'b0;
         cmd_q            <= 1'b0;
         cmd_qq           <= 1'b0;
         clr_q            <= 1'b0;
         debug_info_clear <= 1'b0;
         start_reset      <= 1'b0;
      end
      else
      begin
         reg_bus.ack <= reg_bus.wr | reg_bus.rd;
         reg_bus.err <= (reg_bus.rd && !rd_hit) ||
                        (reg_bus.wr && !(wr_cmd_hit || wr_clr_hit));
         cmd_q       <= reg_bus.wr && wr_cmd_hit && reg_bus.wdata[0];
         clr_q       <= reg_bus.wr && wr_clr_hit && reg_bus.wdata[0];
         debug_info_clear <= clr_q;                  // Lines up with done
         cmd_qq      <= cmd_q;
         start_reset <= cmd_qq;                      // Reset starts after the reply
      end
   end

endmodule

`default_nettype wire

// ==== hw/mmio_access_fsm.sv ====
/*
 * MMIO access sequencer
 * Checks the access width against its area, then strobes either the
 * global register file or the action's local bus. One access at a time,
 * answered with a single done or failed pulse
 */
`default_nettype none
`include "mmio_defs.svh"

module mmio_access_fsm
(
   input  logic                     clk,
   input  logic                     rst_n,
   // Host side
   input  logic                     mmio_wr,
   input  logic                     mmio_rd,
   input  logic                     mmio_dw,          // High for 8-byte
   input  logic [`MMIO_ADDR_W-1:0]  mmio_addr,
   input  logic [`MMIO_DATA_W-1:0]  mmio_din,
   output logic [`MMIO_DATA_W-1:0]  mmio_dout,
   output logic                     mmio_done,
   output logic                     mmio_failed,
   // Action side
   output logic                     lcl_mmio_wr,
   output logic                     lcl_mmio_rd,
   output logic [`MMIO_ADDR_W-1:0]  lcl_mmio_addr,
   output logic [`LCL_DATA_W-1:0]   lcl_mmio_din,
   input  logic                     lcl_mmio_ack,
   input  logic                     lcl_mmio_rsp,     // 1 good, 0 bad
   input  logic [`LCL_DATA_W-1:0]   lcl_mmio_dout,
   input  logic                     lcl_mmio_dv,
   // Global registers
   mmio_reg_if.seq                  reg_bus
);

   mmio_pkg::access_state_e  state;
   mmio_pkg::mmio_addr_u     req_addr;               // Incoming address
   mmio_pkg::mmio_addr_u     addr_q;                 // Held for the access
   logic [`MMIO_DATA_W-1:0]  wdata_q;
   logic [`MMIO_DATA_W-1:0]  act_rdata;
   logic                     is_rd_q;
   logic                     req;
   logic                     width_bad;

   assign req_addr  = mmio_addr;
   assign req       = mmio_wr | mmio_rd;
   assign width_bad = req_addr.act.area ? mmio_dw : ~mmio_dw;   // Action 4B, global 8B

   // Action address without the area bit, data half picked by bit 2
   assign lcl_mmio_addr = {1'b0, addr_q.act.addr};
   assign lcl_mmio_din  = addr_q.act.addr[2] ? wdata_q[`MMIO_DATA_W-1:`LCL_DATA_W]
                                             : wdata_q[`LCL_DATA_W-1:0];
   assign act_rdata     = addr_q.act.addr[2] ? {lcl_mmio_dout, {`LCL_DATA_W{1'b0}}}
                                             : {{`LCL_DATA_W{1'b0}}, lcl_mmio_dout};

   assign reg_bus.addr  = addr_q;
   assign reg_bus.wdata = wdata_q;

   // Request payload, captured once per access
   always_ff @(posedge clk)
   begin
      if (state == mmio_pkg::IDLE && req)
      begin
         addr_q  <= req_addr;
         wdata_q <= mmio_din;
      end
   end

   // ========================================================================
   // Access sequencing
   // ========================================================================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= mmio_pkg::IDLE;
         is_rd_q     <= 1'b0;
         mmio_done   <= 1'b0;
         mmio_failed <= 1'b0;
         mmio_dout   <= '0;
         lcl_mmio_wr <= 1'b0;
         lcl_mmio_rd <= 1'b0;
         reg_bus.wr  <= 1'b0;
         reg_bus.rd  <= 1'b0;
      end
      else
      begin
         mmio_done   <= 1'b0;                        // All pulses by default
         mmio_failed <= 1'b0;
         lcl_mmio_wr <= 1'b0;
         lcl_mmio_rd <= 1'b0;
         reg_bus.wr  <= 1'b0;
         reg_bus.rd  <= 1'b0;
         case (state)
            mmio_pkg::IDLE:
               if (req)
               begin
                  is_rd_q <= mmio_rd;
                  if (width_bad)
                  begin
                     mmio_failed <= 1'b1;            // Reject right away
                     state       <= mmio_pkg::REPLY;
                  end
                  else if (req_addr.act.area)
                  begin
                     lcl_mmio_wr <= mmio_wr;
                     lcl_mmio_rd <= mmio_rd;
                     state       <= mmio_pkg::ACTION;
                  end
                  else
                  begin
                     reg_bus.wr <= mmio_wr;
                     reg_bus.rd <= mmio_rd;
                     state      <= mmio_pkg::GLOBAL;
                  end
               end
            mmio_pkg::GLOBAL:
               if (reg_bus.ack)
               begin
                  mmio_done   <= ~reg_bus.err;
                  mmio_failed <= reg_bus.err;
                  if (is_rd_q && !reg_bus.err)
                     mmio_dout <= reg_bus.rdata;     // Full 64 bits
                  state <= mmio_pkg::REPLY;
               end
            mmio_pkg::ACTION:                        // No timeout, action may stall
               if (lcl_mmio_ack || lcl_mmio_dv)
               begin
                  mmio_done   <= lcl_mmio_rsp;
                  mmio_failed <= ~lcl_mmio_rsp;
                  if (lcl_mmio_dv && lcl_mmio_rsp)
                     mmio_dout <= act_rdata;
                  state <= mmio_pkg::REPLY;
               end
            default:
               state <= mmio_pkg::IDLE;              // REPLY, pulse is out
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/mmio_reg_if.sv ====
/*
 * Global register access channel
 * Sequencer strobes one access, register file answers with ack/err
 */
`default_nettype none
`include "mmio_defs.svh"

interface mmio_reg_if;

   logic                       wr;       // One-cycle strobes
   logic                       rd;
   mmio_pkg::mmio_addr_u       addr;
   logic [`MMIO_DATA_W-1:0]    wdata;
   logic [`MMIO_DATA_W-1:0]    rdata;    // Valid with ack on a read
   logic                       ack;
   logic                       err;      // No such register for this direction

   modport seq  (output wr, rd, addr, wdata, input  rdata, ack, err);
   modport regs (input  wr, rd, addr, wdata, output rdata, ack, err);

endinterface

`default_nettype wire

// ==== hw/mmio_pkg.sv ====
/*
 * MMIO slave types
 * Host address views and sequencer states
 */
`default_nettype none
`include "mmio_defs.svh"

package mmio_pkg;

   // One host address, decoded per area
   typedef union packed
   {
      struct packed
      {
         logic                                                 area;   // 0 here
         logic [`MMIO_ADDR_W-`MMIO_BASE_W-`MMIO_OFFSET_W-2:0] pasid;  // Unused
         logic [`MMIO_BASE_W-1:0]                              base;
         logic [`MMIO_OFFSET_W-1:0]                            offset;
      } glb;
      struct packed
      {
         logic                     area;                 // 1 here
         logic [`MMIO_ADDR_W-2:0]  addr;                 // Passed to the action
      } act;
   } mmio_addr_u;

   // Sequencer states
   typedef enum logic [1:0] {IDLE, GLOBAL, ACTION, REPLY} access_state_e;

endpackage

`default_nettype wire

// ==== include/mmio_defs.svh ====
/*
 * MMIO slave constants
 * Bus widths, global register map and identity words
 */
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// ==========================================================================
// Widths
// ==========================================================================
`define MMIO_DATA_W        64          // Host data, 8-byte registers
`define MMIO_ADDR_W        32
`define LCL_DATA_W         32          // Action side, 4-byte registers
`define MMIO_BASE_W        14          // Address bits 21:8
`define MMIO_OFFSET_W      8           // Address bits 7:0
`define FIR_BRIDGE_W       4           // Top bits of the bridge debug bus

// ==========================================================================
// Global register map
// ==========================================================================
`define BASE_INFRA         14'h0000
`define BASE_DEBUG         14'h01A0
`define BASE_FIR           14'h01C0

`define OFS_IMP_VERSION    8'h00       // RO
`define OFS_BUILD_DATE     8'h08       // RO
`define OFS_COMMAND        8'h10       // WO, bit 0 starts soft reset
`define OFS_STATUS         8'h18       // RO
`define OFS_CAPABILITY     8'h30       // RO

`define OFS_DBG_CLEAR      8'h00       // WO, self-clearing
`define OFS_CNT_AXI_CMD    8'h40
`define OFS_CNT_AXI_RSP    8'h48
`define OFS_BUF_CNT        8'h50

`define OFS_FIR_BRIDGE     8'h00

// Identity
`define MMIO_IMP_VERSION   64'h1000_0000_0000_0000
`define MMIO_BUILD_DATE    64'h0000_2000_0101_0800
`define MMIO_OTHER_CAP     56'h00_0000_0000_0000
`define MMIO_CARD_TYPE     8'h31

`define SOFT_RESET_CYCLES  16          // Length of the soft-reset pulse

`endif
